// ==== common/forth_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forth machine opcode set and
// operand classification
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package forth_pkg;

    localparam int OP_W = 8;            // opcode and program byte width

    typedef enum logic [OP_W-1:0] {
        OP_NOP     = 8'h00,
        OP_HALT    = 8'h01,
        OP_LIT     = 8'h02,             // + immediate byte
        OP_BRANCH  = 8'h03,             // + absolute target
        OP_ZBRANCH = 8'h04,             // + absolute target
        OP_DUP     = 8'h10,
        OP_DROP    = 8'h11,
        OP_OVER    = 8'h12,
        OP_TOR     = 8'h13,             // >r
        OP_RFROM   = 8'h14,             // r>
        OP_RAT     = 8'h15,             // r@
        OP_ADD     = 8'h20,
        OP_SUB     = 8'h21,
        OP_MUL     = 8'h22,
        OP_AND     = 8'h23,
        OP_OR      = 8'h24,
        OP_XOR     = 8'h25,
        OP_ABS     = 8'h26,
        OP_NEG     = 8'h27,             // bitwise invert
        OP_MAX     = 8'h28,
        OP_MIN     = 8'h29,
        OP_ZEQ     = 8'h30,
        OP_ZLT     = 8'h31,
        OP_ZGT     = 8'h32,
        OP_EQ      = 8'h33,
        OP_NE      = 8'h34,
        OP_GT      = 8'h35,
        OP_LT      = 8'h36,
        OP_GE      = 8'h37,
        OP_LE      = 8'h38
    } opcode_e;

    // opcodes followed by one operand byte in program memory
    function automatic logic has_operand(opcode_e op);
        return (op == OP_LIT) || (op == OP_BRANCH) || (op == OP_ZBRANCH);
    endfunction

endpackage

// ==== hdl/prog_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte program memory, loader
// write and registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module prog_mem import forth_pkg::*; #(
    parameter int ASZ = 8
) (
    input  logic            clk,
    input  logic            we,         // loader strobe
    input  logic [ASZ-1:0]  waddr,
    input  logic [OP_W-1:0] wdata,
    input  logic [ASZ-1:0]  raddr,      // instruction pointer
    output logic [OP_W-1:0] rdata
);
    localparam int WORDS = 2 ** ASZ;

    logic [OP_W-1:0] mem [WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hdl/stack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lifo of data cells with fault
// pulses on over/underflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module stack #(
    parameter int DSZ   = 32,
    parameter int DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push,
    input  logic           pop,
    input  logic [DSZ-1:0] din,
    output logic [DSZ-1:0] s,           // entry at the top
    output logic           ovf,
    output logic           unf
);
    localparam int PW = $clog2(DEPTH + 1);  // counts 0..DEPTH
    localparam int IW = $clog2(DEPTH);

    logic [DSZ-1:0] mem [DEPTH];
    logic [PW-1:0]  sp;                 // entries held
    logic           full;
    logic           empty;
    logic [IW-1:0]  top_idx;

    assign full    = (sp == PW'(DEPTH));
    assign empty   = (sp == '0);
    assign top_idx = IW'(sp - 1'b1);
    assign s       = empty ? '0 : mem[top_idx];  // reads 0 when empty

    always_ff @(posedge clk) begin
        if (rst) begin
            sp  <= '0;
            ovf <= 1'b0;
            unf <= 1'b0;
        end else begin
            ovf <= push && full;        // one cycle pulse, contents kept
            unf <= pop && empty;
            if (push && !full) begin
                sp <= sp + 1'b1;
            end else if (pop && !empty) begin
                sp <= sp - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[IW'(sp)] <= din;        // next free slot
        end
    end

endmodule

// ==== exec/exec_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run control fsm: fetch, execute
// and operand cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module exec_ctrl import forth_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  opcode_e op,                 // valid in EXEC
    input  logic    tos_zero,
    input  logic    stk_err,
    output logic    ip_rst,
    output logic    ip_inc,
    output logic    ip_load,
    output logic    exec_en,
    output logic    opnd_en,
    output logic    busy,
    output logic    done,
    output logic    err
);
    typedef enum logic [2:0] {IDLE, FETCH, EXEC, OPND, HALT} state_e;

    state_e  state;
    opcode_e op_q;                      // opcode that owns the operand byte
    logic    opnd_wait;                 // first OPND cycle, byte still in flight
    logic    idle;
    logic    zb_taken;

    assign idle     = (state == IDLE) || (state == HALT);
    assign busy     = !idle;
    assign ip_rst   = idle && start;
    assign exec_en  = (state == EXEC) && !stk_err;
    assign opnd_en  = (state == OPND) && !opnd_wait && !stk_err;
    assign zb_taken = (op_q == OP_ZBRANCH) && tos_zero;

    // step past opcode, or past operand unless a branch loads ip
    assign ip_inc  = (exec_en && op != OP_HALT) ||
                     (opnd_en && (op_q == OP_LIT || (op_q == OP_ZBRANCH && !tos_zero)));
    assign ip_load = opnd_en && (op_q == OP_BRANCH || zb_taken);

    always_ff @(posedge clk) begin
        if (exec_en) begin
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            opnd_wait <= 1'b0;
            done      <= 1'b0;
            err       <= 1'b0;
        end else begin
            case (state)
                IDLE, HALT: begin
                    if (start) begin
                        state <= FETCH;
                        done  <= 1'b0;
                        err   <= 1'b0;
                    end
                end
                FETCH: state <= EXEC;   // read of ip completes
                EXEC: begin
                    if (op == OP_HALT) begin
                        state <= HALT;
                        done  <= 1'b1;
                    end else if (has_operand(op)) begin
                        state     <= OPND;
                        opnd_wait <= 1'b1;
                    end else begin
                        state <= FETCH;
                    end
                end
                OPND: begin
                    if (opnd_wait) begin
                        opnd_wait <= 1'b0;
                    end else begin
                        state <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
            if (busy && stk_err) begin  // stack fault ends the run
                state     <= HALT;
                opnd_wait <= 1'b0;
                done      <= 1'b1;
                err       <= 1'b1;
            end
        end
    end

endmodule

// ==== exec/ip_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction pointer with clear,
// branch load and increment
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ip_counter #(
    parameter int ASZ = 8,
    parameter int IP0 = 0               // start address
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           clr,         // start of a run
    input  logic           inc,
    input  logic           load,        // branch taken
    input  logic [ASZ-1:0] target,
    output logic [ASZ-1:0] ip
);
    localparam logic [ASZ-1:0] START = ASZ'(IP0);

    // priority clr, load, inc
    always_ff @(posedge clk) begin
        if (rst) begin
            ip <= START;
        end else if (clr) begin
            ip <= START;
        end else if (load) begin
            ip <= target;
        end else if (inc) begin
            ip <= ip + 1'b1;            // wraps at top of memory
        end
    end

endmodule

// ==== exec/exec_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execution unit: tos register,
// alu/compare, data and return stacks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module exec_unit import forth_pkg::*; #(
    parameter int DSZ   = 32,
    parameter int DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,    // op on the bus
    input  logic            opnd_en,    // operand byte on the bus
    input  opcode_e         op,
    input  logic [OP_W-1:0] operand,
    output logic [DSZ-1:0]  tos,
    output logic            tos_zero,
    output logic            stk_err
);
    opcode_e        op_q;               // held across the operand fetch
    logic [DSZ-1:0] tos_nxt;
    logic [DSZ-1:0] nos;                // data stack top, the left operand
    logic [DSZ-1:0] rs_top;
    logic           en;
    logic           ds_push;
    logic           ds_pop;
    logic           rs_push;
    logic           rs_pop;
    logic           ds_ovf;
    logic           ds_unf;
    logic           rs_ovf;
    logic           rs_unf;

    assign en       = exec_en || opnd_en;
    assign tos_zero = (tos == '0);
    assign stk_err  = ds_ovf || ds_unf || rs_ovf || rs_unf;

    always_ff @(posedge clk) begin
        if (exec_en && has_operand(op)) begin
            op_q <= op;
        end
    end

    always_comb begin
        tos_nxt = tos;
        ds_push = 1'b0;
        ds_pop  = 1'b0;
        rs_push = 1'b0;
        rs_pop  = 1'b0;
        if (opnd_en) begin              // second half of lit / 0branch
            ds_push = (op_q == OP_LIT);
            ds_pop  = (op_q == OP_ZBRANCH);   // flag always dropped
            if (op_q == OP_LIT) begin
                tos_nxt = DSZ'(operand);      // zero extend
            end else if (op_q == OP_ZBRANCH) begin
                tos_nxt = nos;
            end
        end else if (exec_en) begin
            ds_push = op inside {OP_DUP, OP_OVER, OP_RFROM, OP_RAT};
            ds_pop  = op inside {OP_DROP, OP_TOR, OP_ADD, OP_SUB, OP_MUL, OP_AND,
                                 OP_OR, OP_XOR, OP_MAX, OP_MIN, OP_EQ, OP_NE,
                                 OP_GT, OP_LT, OP_GE, OP_LE};
            rs_push = (op == OP_TOR);
            rs_pop  = (op == OP_RFROM);
            case (op)
                // flow, return stack
                OP_TOR:   tos_nxt = nos;
                OP_RFROM: tos_nxt = rs_top;
                OP_RAT:   tos_nxt = rs_top;     // copy, rs untouched
                // stack words, dup keeps tos
                OP_DROP:  tos_nxt = nos;
                OP_OVER:  tos_nxt = nos;
                // alu, nos op tos
                OP_ADD:   tos_nxt = nos + tos;
                OP_SUB:   tos_nxt = nos - tos;
                OP_MUL:   tos_nxt = nos * tos;  // low half only
                OP_AND:   tos_nxt = nos & tos;
                OP_OR:    tos_nxt = nos | tos;
                OP_XOR:   tos_nxt = nos ^ tos;
                OP_ABS:   tos_nxt = ($signed(tos) < 0) ? -tos : tos;
                OP_NEG:   tos_nxt = ~tos;
                OP_MAX:   tos_nxt = ($signed(nos) > $signed(tos)) ? nos : tos;
                OP_MIN:   tos_nxt = ($signed(nos) < $signed(tos)) ? nos : tos;
                // compares give 1 or 0
                OP_ZEQ:   tos_nxt = DSZ'(tos == '0);
                OP_ZLT:   tos_nxt = DSZ'($signed(tos) < 0);
                OP_ZGT:   tos_nxt = DSZ'($signed(tos) > 0);
                OP_EQ:    tos_nxt = DSZ'(nos == tos);
                OP_NE:    tos_nxt = DSZ'(nos != tos);
                OP_GT:    tos_nxt = DSZ'(nos > tos);   // unsigned
                OP_LT:    tos_nxt = DSZ'(nos < tos);
                OP_GE:    tos_nxt = DSZ'(nos >= tos);
                OP_LE:    tos_nxt = DSZ'(nos <= tos);
                default:  tos_nxt = tos;        // nop, halt, dup, operand words
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tos <= '0;
        end else if (en) begin
            tos <= tos_nxt;
        end
    end

    // old tos is what gets pushed on either stack
    stack #(.DSZ(DSZ), .DEPTH(DEPTH)) i_ds (
        .clk, .rst,
        .push (ds_push),
        .pop  (ds_pop),
        .din  (tos),
        .s    (nos),
        .ovf  (ds_ovf),
        .unf  (ds_unf)
    );

    stack #(.DSZ(DSZ), .DEPTH(DEPTH)) i_rs (
        .clk, .rst,
        .push (rs_push),
        .pop  (rs_pop),
        .din  (tos),
        .s    (rs_top),
        .ovf  (rs_ovf),
        .unf  (rs_unf)
    );

endmodule

// ==== hdl/forth_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forth stack machine top, loader
// port plus run control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module forth_top import forth_pkg::*; #(
    parameter int DSZ   = 32,           // data cell width
    parameter int ASZ   = 8,            // program address width
    parameter int DEPTH = 16,           // entries per stack
    parameter int IP0   = 0             // start address
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_we,
    input  logic [ASZ-1:0]  load_addr,
    input  logic [OP_W-1:0] load_data,
    input  logic            start,
    output logic            busy,
    output logic            done,
    output logic            err,
    output logic [DSZ-1:0]  tos
);
    logic [ASZ-1:0]  ip;
    logic [OP_W-1:0] mem_data;          // opcode or operand, one cycle after ip
    logic            ip_rst;
    logic            ip_inc;
    logic            ip_load;
    logic            exec_en;
    logic            opnd_en;
    logic            tos_zero;
    logic            stk_err;

    exec_ctrl i_ctrl (
        .clk, .rst, .start,
        .op       (opcode_e'(mem_data)),
        .tos_zero, .stk_err,
        .ip_rst, .ip_inc, .ip_load, .exec_en, .opnd_en,
        .busy, .done, .err
    );

    ip_counter #(.ASZ(ASZ), .IP0(IP0)) i_ip (
        .clk, .rst,
        .clr    (ip_rst),
        .inc    (ip_inc),
        .load   (ip_load),
        .target (mem_data[ASZ-1:0]),    // branch byte is the target
        .ip
    );

    prog_mem #(.ASZ(ASZ)) i_mem (
        .clk,
        .we    (load_we),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (ip),
        .rdata (mem_data)
    );

    // start also clears tos and both stacks for a clean rerun
    exec_unit #(.DSZ(DSZ), .DEPTH(DEPTH)) i_exec (
        .clk,
        .rst     (rst || ip_rst),
        .exec_en, .opnd_en,
        .op      (opcode_e'(mem_data)),
        .operand (mem_data),
        .tos, .tos_zero, .stk_err
    );

endmodule

// ==== bench/clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 10 ns period,
// and a 5 cycle synchronous reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module clk_gen #(
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial clk = 1'b0;
    always #5 clk = ~clk;               // 100 MHz

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;                    // released on an edge
    end

endmodule

// ==== bench/forth_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol checks on the stack
// strobes and run status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module forth_properties (
    input logic clk,
    input logic rst,
    input logic exec_en,
    input logic opnd_en,
    input logic ds_push,
    input logic ds_pop,
    input logic rs_push,
    input logic rs_pop,
    input logic busy,
    input logic done
);
    // a stack sees one strobe per cycle at most
    a_ds_one_op: assert property (@(posedge clk) disable iff (rst) !(ds_push && ds_pop))
        else $error("data stack got push and pop together");
    a_rs_one_op: assert property (@(posedge clk) disable iff (rst) !(rs_push && rs_pop))
        else $error("return stack got push and pop together");

    // opcode and operand phases never overlap
    a_en_excl: assert property (@(posedge clk) disable iff (rst) !(exec_en && opnd_en))
        else $error("exec_en and opnd_en high together");

    a_done_idle: assert property (@(posedge clk) disable iff (rst) !(done && busy))
        else $error("done high while busy");

endmodule

// stack strobes live inside the execution unit
bind forth_top forth_properties i_props (
    .clk     (clk),
    .rst     (rst),
    .exec_en (exec_en),
    .opnd_en (opnd_en),
    .ds_push (i_exec.ds_push),
    .ds_pop  (i_exec.ds_pop),
    .rs_push (i_exec.rs_push),
    .rs_pop  (i_exec.rs_pop),
    .busy    (busy),
    .done    (done)
);

// ==== bench/tb_forth.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the forth machine,
// program table run through loader
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_forth import forth_pkg::*; ();
    localparam int DSZ     = 32;
    localparam int ASZ     = 8;
    localparam int MAXROWS = 64;
    localparam int MAXB    = 40;        // 17 lits need 35 bytes
    localparam int TMO     = 500;       // cycles allowed per run

    logic            clk;
    logic            rst;
    logic            load_we;
    logic [ASZ-1:0]  load_addr;
    logic [OP_W-1:0] load_data;
    logic            start;
    logic            busy;
    logic            done;
    logic            err;
    logic [DSZ-1:0]  tos;

    // program table
    logic [7:0]      prog_tab [MAXROWS][MAXB];
    int              len_tab  [MAXROWS];
    logic [DSZ-1:0]  tos_tab  [MAXROWS];
    logic            err_tab  [MAXROWS];
    int              nrows;
    logic [7:0]      pq [$];            // row under construction

    clk_gen i_clk (.clk, .rst);

    forth_top #(.DSZ(DSZ), .ASZ(ASZ), .DEPTH(16), .IP0(0)) i_dut (
        .clk, .rst, .load_we, .load_addr, .load_data, .start,
        .busy, .done, .err, .tos
    );

    task automatic check(input string name, input logic [DSZ-1:0] got,
                         input logic [DSZ-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic emit(input opcode_e op);
        pq.push_back(op);
    endtask

    task automatic emit_op2(input opcode_e op, input logic [7:0] b);
        pq.push_back(op);
        pq.push_back(b);               // literal or branch target
    endtask

    task automatic end_row(input logic [DSZ-1:0] t, input logic e);
        for (int i = 0; i < pq.size(); i++) begin
            prog_tab[nrows][i] = pq[i];
        end
        len_tab[nrows] = pq.size();
        tos_tab[nrows] = t;
        err_tab[nrows] = e;
        nrows++;
        pq.delete();
    endtask

    // LIT a, LIT b, op, HALT
    task automatic row_bin(input logic [7:0] a, input logic [7:0] b, input opcode_e op,
                           input logic [DSZ-1:0] t);
        emit_op2(OP_LIT, a);
        emit_op2(OP_LIT, b);
        emit(op);
        emit(OP_HALT);
        end_row(t, 1'b0);
    endtask

    // LIT a, optional NEG, op, HALT
    task automatic row_unary(input logic [7:0] a, input bit inv, input opcode_e op,
                             input logic [DSZ-1:0] t);
        emit_op2(OP_LIT, a);
        if (inv) begin
            emit(OP_NEG);               // ~a, a negative cell
        end
        emit(op);
        emit(OP_HALT);
        end_row(t, 1'b0);
    endtask

    // left operand -6 and right operand 3
    task automatic row_neg3(input opcode_e op, input logic [DSZ-1:0] t);
        emit_op2(OP_LIT, 8'd5);
        emit(OP_NEG);                   // ~5 is -6
        emit_op2(OP_LIT, 8'd3);
        emit(op);
        emit(OP_HALT);
        end_row(t, 1'b0);
    endtask

    // next op tos per the operand rule
    function automatic logic [DSZ-1:0] expect_bin(input opcode_e op, input logic [DSZ-1:0] l,
                                                  input logic [DSZ-1:0] r);
        case (op)
            OP_ADD:  return l + r;
            OP_SUB:  return l - r;
            OP_MUL:  return l * r;
            OP_AND:  return l & r;
            OP_OR:   return l | r;
            OP_XOR:  return l ^ r;
            OP_MAX:  return ($signed(l) >= $signed(r)) ? l : r;
            OP_MIN:  return ($signed(l) <= $signed(r)) ? l : r;
            OP_EQ:   return (l == r) ? 1 : 0;
            OP_NE:   return (l != r) ? 1 : 0;
            OP_GT:   return (l > r) ? 1 : 0;
            OP_LT:   return (l < r) ? 1 : 0;
            OP_GE:   return (l >= r) ? 1 : 0;
            default: return (l <= r) ? 1 : 0;   // le
        endcase
    endfunction

    function automatic opcode_e pick_op(input int k);
        case (k)
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_MUL;
            3:       return OP_AND;
            4:       return OP_OR;
            5:       return OP_XOR;
            6:       return OP_MAX;
            7:       return OP_MIN;
            8:       return OP_EQ;
            9:       return OP_NE;
            10:      return OP_GT;
            11:      return OP_LT;
            12:      return OP_GE;
            default: return OP_LE;
        endcase
    endfunction

    task automatic build_table();
        logic [7:0] a;
        logic [7:0] b;
        opcode_e    op;
        // alu
        row_bin(8'd20, 8'd7, OP_ADD, 32'd27);
        row_bin(8'd7, 8'd20, OP_SUB, 32'hffff_fff3);
        row_bin(8'd12, 8'd11, OP_MUL, 32'd132);
        row_bin(8'hf0, 8'h3c, OP_AND, 32'h30);
        row_bin(8'hf0, 8'h3c, OP_OR, 32'hfc);
        row_bin(8'hf0, 8'h3c, OP_XOR, 32'hcc);
        row_unary(8'd5, 1'b0, OP_NEG, 32'hffff_fffa);
        row_unary(8'd5, 1'b1, OP_ABS, 32'd6);
        row_neg3(OP_MAX, 32'd3);        // signed
        row_neg3(OP_MIN, 32'hffff_fffa);
        // compares
        row_unary(8'd0, 1'b0, OP_ZEQ, 32'd1);
        row_unary(8'd4, 1'b0, OP_ZEQ, 32'd0);
        row_unary(8'd5, 1'b1, OP_ZLT, 32'd1);
        row_unary(8'd5, 1'b0, OP_ZLT, 32'd0);
        row_unary(8'd5, 1'b0, OP_ZGT, 32'd1);
        row_unary(8'd5, 1'b1, OP_ZGT, 32'd0);
        row_bin(8'd9, 8'd9, OP_EQ, 32'd1);
        row_bin(8'd9, 8'd8, OP_NE, 32'd1);
        row_neg3(OP_GT, 32'd1);         // unsigned so -6 is huge
        row_neg3(OP_LT, 32'd0);
        row_bin(8'd3, 8'd3, OP_GE, 32'd1);
        row_bin(8'd4, 8'd3, OP_LE, 32'd0);
        // stack words
        emit_op2(OP_LIT, 8'd5);
        emit(OP_DUP);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd10, 1'b0);
        emit_op2(OP_LIT, 8'd2);
        emit_op2(OP_LIT, 8'd7);
        emit(OP_OVER);
        emit(OP_ADD);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd11, 1'b0);          // 2 + (7 + 2)
        emit_op2(OP_LIT, 8'd4);
        emit(OP_NOP);
        emit_op2(OP_LIT, 8'd9);
        emit(OP_DROP);
        emit(OP_HALT);
        end_row(32'd4, 1'b0);
        emit_op2(OP_LIT, 8'd6);
        emit(OP_TOR);
        emit_op2(OP_LIT, 8'd1);
        emit(OP_RFROM);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd7, 1'b0);
        emit_op2(OP_LIT, 8'd6);
        emit(OP_TOR);
        emit(OP_RAT);
        emit(OP_RAT);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd12, 1'b0);
        // branch over the lit at 4
        emit_op2(OP_LIT, 8'd3);
        emit_op2(OP_BRANCH, 8'd6);
        emit_op2(OP_LIT, 8'd7);
        emit(OP_HALT);
        end_row(32'd3, 1'b0);
        // zbranch to the halt at 9 on zero
        // flag is dropped so 8 is left
        emit_op2(OP_LIT, 8'd8);
        emit_op2(OP_LIT, 8'd0);
        emit_op2(OP_ZBRANCH, 8'd9);
        emit_op2(OP_LIT, 8'd5);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd8, 1'b0);
        // nonzero flag falls through to 8 + 5
        emit_op2(OP_LIT, 8'd8);
        emit_op2(OP_LIT, 8'd1);
        emit_op2(OP_ZBRANCH, 8'd9);
        emit_op2(OP_LIT, 8'd5);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd13, 1'b0);
        // countdown from 3 then 0 + 42
        emit_op2(OP_LIT, 8'd3);
        emit(OP_DUP);
        emit_op2(OP_ZBRANCH, 8'd10);
        emit_op2(OP_LIT, 8'd1);
        emit(OP_SUB);
        emit_op2(OP_BRANCH, 8'd2);
        emit_op2(OP_LIT, 8'd42);
        emit(OP_ADD);
        emit(OP_HALT);
        end_row(32'd42, 1'b0);
        // faults
        emit(OP_DROP);
        emit(OP_HALT);
        end_row(32'd0, 1'b1);           // underflow
        for (int k = 1; k <= 17; k++) begin
            emit_op2(OP_LIT, 8'(k));
        end
        emit(OP_HALT);
        end_row(32'd17, 1'b1);          // 17th push overflows
        // random binary rows
        for (int k = 0; k < 16; k++) begin
            a  = 8'($urandom());
            b  = 8'($urandom());
            op = pick_op(int'($urandom() % 14));
            row_bin(a, b, op, expect_bin(op, DSZ'(a), DSZ'(b)));
        end
    endtask

    task automatic load_prog(input int r);
        for (int i = 0; i < len_tab[r]; i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= ASZ'(i);
            load_data <= prog_tab[r][i];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic run_prog(input int r);
        bit seen;
        seen = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int n = 0; n < TMO && !seen; n++) begin
            @(negedge clk);             // outputs settled
            seen = done;
        end
        if (!seen) begin
            $display("timeout: row %0d did not finish within %0d cycles", r, TMO);
            $display("tests failed");
            $fatal(1, "run timeout");
        end
        check("tos", tos, tos_tab[r]);
        check("err", DSZ'(err), DSZ'(err_tab[r]));
    endtask

    initial begin
        bit rst_gone;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        nrows     = 0;
        void'($urandom(32'h7ed3d71a));
        build_table();

        rst_gone = 1'b0;
        for (int n = 0; n < 50 && !rst_gone; n++) begin
            @(negedge clk);
            rst_gone = !rst;
        end
        if (!rst_gone) begin
            $display("timeout: reset never released");
            $display("tests failed");
            $fatal(1, "reset timeout");
        end
        check("busy", DSZ'(busy), '0);
        check("done", DSZ'(done), '0);
        check("err", DSZ'(err), '0);
        check("tos", tos, '0);

        for (int r = 0; r < nrows; r++) begin
            load_prog(r);
            run_prog(r);
            run_prog(r);                // restart from ip0 gives the same result
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tb.f ====
common/forth_pkg.sv
hdl/prog_mem.sv
hdl/stack.sv
exec/exec_ctrl.sv
exec/ip_counter.sv
exec/exec_unit.sv
hdl/forth_top.sv
bench/clk_gen.sv
bench/forth_properties.sv
bench/tb_forth.sv

// ==== run.sh ====
#!/bin/sh
# build and run the forth machine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_forth -f tb.f -o sim_forth

./obj_dir/sim_forth | tee sim.log || true

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
